// ==== Makefile ====
TOP = tb_ulpi_link

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
hw/ulpi_pkg.sv
hw/ulpi_rx_cmd_decoder.sv
hw/ulpi_tx_cmd_engine.sv
hw/ulpi_link_fsm.sv
hw/ulpi_link_top.sv
dv/ulpi_link_checker.sv
dv/tb_ulpi_link.sv

// ==== dv/tb_ulpi_link.sv ====
module tb_ulpi_link;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CYCLE_LIMIT = 2000;

   logic       clk_suspend;
   logic       reset_2;
   logic       opt_disable_all;
   logic       opt_ignore_vbus;
   logic       stat_connected;
   logic       se0_reset;
   logic [1:0] dbg_linestate;
   logic [7:0] phy_d_in;
   logic [7:0] phy_d_out_mux;
   logic       phy_d_oe;
   logic       phy_dir;
   logic       phy_stp;
   logic       phy_nxt;
   logic       pkt_out_act;
   logic [7:0] pkt_out_byte;
   logic       pkt_out_latch;
   logic       pkt_in_cts;
   logic       pkt_in_nxt;
   logic [7:0] pkt_in_byte;
   logic       pkt_in_latch;
   logic       pkt_in_stp;

   int errors;
   int tests_passed;
   int tests_failed;
   int cycles;
   int se0_pulses;

   ulpi_link_top dut_i (
      .clk_suspend     (clk_suspend),
      .reset_2         (reset_2),
      .opt_disable_all (opt_disable_all),
      .opt_ignore_vbus (opt_ignore_vbus),
      .stat_connected  (stat_connected),
      .se0_reset       (se0_reset),
      .dbg_linestate   (dbg_linestate),
      .phy_d_in        (phy_d_in),
      .phy_d_out_mux   (phy_d_out_mux),
      .phy_d_oe        (phy_d_oe),
      .phy_dir         (phy_dir),
      .phy_stp         (phy_stp),
      .phy_nxt         (phy_nxt),
      .pkt_out_act     (pkt_out_act),
      .pkt_out_byte    (pkt_out_byte),
      .pkt_out_latch   (pkt_out_latch),
      .pkt_in_cts      (pkt_in_cts),
      .pkt_in_nxt      (pkt_in_nxt),
      .pkt_in_byte     (pkt_in_byte),
      .pkt_in_latch    (pkt_in_latch),
      .pkt_in_stp      (pkt_in_stp)
   );

   //////////////////////////////////////////////////
   // clock, timeout, pulse monitor
   //////////////////////////////////////////////////

   initial clk_suspend = 1'b0;
   always #20 clk_suspend = ~clk_suspend;

   always @(posedge clk_suspend) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // sampled mid-cycle, away from the edges
   always @(negedge clk_suspend) begin
      if (reset_2 && se0_reset) se0_pulses <= se0_pulses + 1;
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         $display("Error: %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   // procedural errors plus failed assertions in the bound checker
   function automatic int error_total();
      return errors + dut_i.chk_i.assert_fails;
   endfunction

   task automatic next_drive();
      @(posedge clk_suspend);
      #5;
   endtask

   // behavioral phy: hold off nxt for a random 0..3 cycles
   task automatic accept_cmd(input logic [7:0] exp_cmd);
      int unsigned stall;
      do @(negedge clk_suspend); while (phy_d_out_mux == 8'h00 || dut_i.pkt_d_sel);
      check_val("phy_d_out_mux", exp_cmd, phy_d_out_mux);
      // link owns the bus while it drives a command
      check_val("phy_d_oe", 8'h01, {7'd0, phy_d_oe});
      stall = $urandom % 4;
      // command must hold while nxt is low
      repeat (stall) begin
         @(negedge clk_suspend);
         check_val("phy_d_out_mux", exp_cmd, phy_d_out_mux);
      end
      next_drive();
      phy_nxt = 1'b1;
      @(negedge clk_suspend);
      check_val("phy_d_out_mux", exp_cmd, phy_d_out_mux);
      next_drive();
      phy_nxt = 1'b0;
   endtask

   // command byte, data byte, then the stp cycle
   task automatic expect_reg_write(input logic [7:0] exp_cmd, input logic [7:0] exp_data);
      accept_cmd(exp_cmd);
      @(negedge clk_suspend);
      check_val("phy_d_out_mux", exp_data, phy_d_out_mux);
      @(negedge clk_suspend);
      check_val("phy_stp", 8'h01, {7'd0, phy_stp});
   endtask

   // dir for three cycles with nxt low, one rx_cmd byte
   task automatic send_rx_cmd(input logic [7:0] b);
      next_drive();
      phy_dir  = 1'b1;
      phy_nxt  = 1'b0;
      phy_d_in = b;
      repeat (3) @(posedge clk_suspend);
      #5;
      phy_dir  = 1'b0;
      phy_d_in = 8'h00;
      repeat (3) @(posedge clk_suspend);
   endtask

   task automatic report_test(input string name, input int err_start);
      if (error_total() == err_start) begin
         tests_passed++;
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, error_total() - err_start);
      end
   endtask

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      int err_start;
      int pulses_start;
      int writes;
      void'($urandom(66940));
      errors          = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      cycles          = 0;
      se0_pulses      = 0;
      reset_2         = 1'b0;
      opt_disable_all = 1'b0;
      opt_ignore_vbus = 1'b0;
      phy_d_in        = 8'h00;
      phy_dir         = 1'b0;
      phy_nxt         = 1'b0;
      pkt_in_byte     = 8'h00;
      pkt_in_latch    = 1'b0;
      pkt_in_stp      = 1'b0;
      repeat (10) @(posedge clk_suspend);
      #5;
      reset_2 = 1'b1;

      // outputs still at their reset values in the first cycle out of reset
      err_start = error_total();
      @(negedge clk_suspend);
      check_val("phy_stp", 8'h00, {7'd0, phy_stp});
      check_val("phy_d_oe", 8'h00, {7'd0, phy_d_oe});
      check_val("pkt_in_cts", 8'h00, {7'd0, pkt_in_cts});
      check_val("pkt_in_nxt", 8'h00, {7'd0, pkt_in_nxt});
      check_val("se0_reset", 8'h00, {7'd0, se0_reset});
      check_val("pkt_out_act", 8'h00, {7'd0, pkt_out_act});
      report_test("reset values", err_start);

      // bring-up: func ctrl write, rx_cmd with vbus low and line K, otg write
      err_start = error_total();
      expect_reg_write(8'h84, 8'h65);
      send_rx_cmd(8'h02);
      expect_reg_write(8'h8A, 8'h00);
      repeat (3) @(posedge clk_suspend);
      report_test("bring-up", err_start);

      // rx_cmd decode, vbus valid and line J
      err_start = error_total();
      send_rx_cmd(8'h0D);
      @(negedge clk_suspend);
      check_val("stat_connected", 8'h01, {7'd0, stat_connected});
      check_val("dbg_linestate", 8'h01, {6'd0, dbg_linestate});
      report_test("rx_cmd decode", err_start);

      // packet transmit, pid A3
      err_start = error_total();
      // idle link with the bus free
      check_val("pkt_in_cts", 8'h01, {7'd0, pkt_in_cts});
      next_drive();
      pkt_in_latch = 1'b1;
      pkt_in_byte  = 8'hA3;
      next_drive();
      pkt_in_latch = 1'b0;
      accept_cmd(8'h43);
      // busy sending
      check_val("pkt_in_cts", 8'h00, {7'd0, pkt_in_cts});
      for (int i = 0; i < 3; i++) begin
         // one stalled byte in the middle
         pkt_in_byte = 8'h10 + 8'(i);
         phy_nxt     = (i != 1);
         @(negedge clk_suspend);
         check_val("phy_d_out_mux", pkt_in_byte, phy_d_out_mux);
         check_val("pkt_in_nxt", {7'd0, phy_nxt}, {7'd0, pkt_in_nxt});
         next_drive();
      end
      phy_nxt    = 1'b0;
      pkt_in_stp = 1'b1;
      @(negedge clk_suspend);
      check_val("phy_stp", 8'h01, {7'd0, phy_stp});
      next_drive();
      pkt_in_stp  = 1'b0;
      pkt_in_byte = 8'h00;
      repeat (2) @(posedge clk_suspend);
      report_test("packet transmit", err_start);

      // receive pass-through, dir and nxt rise together
      err_start = error_total();
      next_drive();
      phy_dir  = 1'b1;
      phy_nxt  = 1'b1;
      phy_d_in = 8'h00;
      next_drive();
      phy_d_in = 8'h11;
      @(negedge clk_suspend);
      check_val("phy_d_oe", 8'h00, {7'd0, phy_d_oe});
      check_val("pkt_out_act", 8'h01, {7'd0, pkt_out_act});
      check_val("pkt_out_latch", 8'h01, {7'd0, pkt_out_latch});
      check_val("pkt_out_byte", 8'h11, pkt_out_byte);
      // nxt low carries an rx_cmd, rx active, vbus valid, J
      next_drive();
      phy_nxt  = 1'b0;
      phy_d_in = 8'h1D;
      @(negedge clk_suspend);
      check_val("pkt_out_act", 8'h01, {7'd0, pkt_out_act});
      check_val("pkt_out_latch", 8'h00, {7'd0, pkt_out_latch});
      next_drive();
      phy_nxt  = 1'b1;
      phy_d_in = 8'h22;
      @(negedge clk_suspend);
      check_val("pkt_out_byte", 8'h22, pkt_out_byte);
      next_drive();
      phy_dir  = 1'b0;
      phy_nxt  = 1'b0;
      phy_d_in = 8'h00;
      repeat (3) @(posedge clk_suspend);
      report_test("receive pass-through", err_start);

      // se0: short run gives nothing, long run gives one pulse
      err_start    = error_total();
      pulses_start = se0_pulses;
      send_rx_cmd(8'h0C);
      repeat (40) @(posedge clk_suspend);
      send_rx_cmd(8'h0D);
      @(negedge clk_suspend);
      check_val("se0_reset pulses", 8'h00, 8'(se0_pulses - pulses_start));
      pulses_start = se0_pulses;
      send_rx_cmd(8'h0C);
      repeat (130) @(posedge clk_suspend);
      @(negedge clk_suspend);
      check_val("se0_reset pulses", 8'h01, 8'(se0_pulses - pulses_start));
      send_rx_cmd(8'h0D);
      report_test("se0 reset", err_start);

      // vbus loss, first masked, then honored
      err_start       = error_total();
      next_drive();
      opt_ignore_vbus = 1'b1;
      send_rx_cmd(8'h01);
      writes = 0;
      repeat (84) begin
         @(negedge clk_suspend);
         if (phy_d_out_mux != 8'h00) writes++;
      end
      if (writes != 0) begin
         $display("vbus loss with opt_ignore_vbus high still restarted bring-up");
         errors++;
      end
      send_rx_cmd(8'h0D);
      next_drive();
      opt_ignore_vbus = 1'b0;
      send_rx_cmd(8'h01);
      expect_reg_write(8'h84, 8'h65);
      report_test("vbus loss", err_start);

      $display("tests passed %0d, failed %0d, errors %0d",
               tests_passed, tests_failed, error_total());
      if (error_total() == 0 && tests_failed == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== dv/ulpi_link_checker.sv ====
module ulpi_link_checker import ulpi_pkg::*; (
   input logic        clk_suspend,
   input logic        reset_2,
   input logic        phy_stp,
   input logic        phy_nxt,
   input logic        phy_dir,
   input ulpi_byte_t  phy_d_in,
   input ulpi_byte_t  phy_d_out_mux,
   input logic        pkt_d_sel,
   input logic        rx_expect,
   input logic        stat_connected,
   input line_state_t dbg_linestate,
   input logic        pkt_out_latch,
   input ulpi_byte_t  pkt_out_byte,
   input logic        se0_reset
);

   timeunit 1ns;
   timeprecision 100ps;

   // count of failed assertions
   int assert_fails = 0;

   //////////////////////////////////////////////////
   // register write stp cycle
   //////////////////////////////////////////////////

   // stp carries zero data, two cycles after nxt took the command
   stp_zero_data: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      (phy_stp && !pkt_d_sel) |-> (phy_d_out_mux == 8'h00 && $past(phy_nxt, 2)))
      else begin
         assert_fails++;
         $error("stp cycle without zero data or not two cycles after nxt");
      end

   // exactly one cycle
   stp_one_cycle: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      (phy_stp && !pkt_d_sel) |=> !phy_stp)
      else begin
         assert_fails++;
         $error("engine stp held for more than one cycle");
      end

   //////////////////////////////////////////////////
   // status from the captured rx_cmd
   //////////////////////////////////////////////////

   // two cycles behind an rx_cmd byte taken off the bus
   connected_follows: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      $past(rx_expect && phy_dir && !phy_nxt, 2)
         |-> stat_connected == ($past(phy_d_in[3:2], 2) == VBUS_VALID))
      else begin
         assert_fails++;
         $error("stat_connected does not follow the rx_cmd vbus state");
      end

   linestate_follows: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      $past(rx_expect && phy_dir && !phy_nxt, 2)
         |-> dbg_linestate == $past(phy_d_in[1:0], 2))
      else begin
         assert_fails++;
         $error("dbg_linestate does not follow the rx_cmd line state");
      end

   // receive path
   rx_byte_zero: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      !pkt_out_latch |-> pkt_out_byte == 8'h00)
      else begin
         assert_fails++;
         $error("pkt_out_byte not zero while latch is low");
      end

   // single pulse
   se0_pulse: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      se0_reset |=> !se0_reset)
      else begin
         assert_fails++;
         $error("se0_reset high for more than one cycle");
      end

endmodule

bind ulpi_link_top ulpi_link_checker chk_i (
   .clk_suspend    (clk_suspend),
   .reset_2        (reset_2),
   .phy_stp        (phy_stp),
   .phy_nxt        (phy_nxt),
   .phy_dir        (phy_dir),
   .phy_d_in       (phy_d_in),
   .phy_d_out_mux  (phy_d_out_mux),
   .pkt_d_sel      (pkt_d_sel),
   .rx_expect      (rx_expect),
   .stat_connected (stat_connected),
   .dbg_linestate  (dbg_linestate),
   .pkt_out_latch  (pkt_out_latch),
   .pkt_out_byte   (pkt_out_byte),
   .se0_reset      (se0_reset)
);

// ==== hw/ulpi_link_fsm.sv ====
module ulpi_link_fsm import ulpi_pkg::*; (
   input  logic       clk_suspend,
   input  logic       reset_2,
   input  logic       opt_disable_all,
   input  logic       opt_ignore_vbus,
   input  logic       phy_dir,
   input  logic       phy_nxt,
   input  rx_cmd_t    rx_cmd,
   input  logic       tx_done,
   input  logic       pkt_in_latch,
   input  ulpi_byte_t pkt_in_byte,
   input  logic       pkt_in_stp,
   output logic       tx_start,
   output tx_req_t    tx_req,
   output logic       rx_expect,
   output logic       pkt_d_sel,
   output logic       pkt_in_cts,
   output logic       se0_reset
);

   link_state_e        state;
   // shared by debounce, dir timeout and se0 timing
   logic [TIMER_W-1:0] timer;
   logic               dir_q;
   logic               dir_rise;
   logic               vbus_valid;
   logic               vbus_valid_q;
   logic               vbus_lost;
   logic               line_se0;
   // latch seen while busy, served from idle
   logic               latch_defer;

   function automatic tx_req_t reg_write_req(input logic [5:0] addr, input ulpi_byte_t data);
      tx_req_t req;
      req.cmd.reg_view.code = CMD_REGWR;
      req.cmd.reg_view.addr = addr;
      req.wr_data           = data;
      req.wr                = 1'b1;
      return req;
   endfunction

   function automatic tx_req_t xmit_req(input logic [3:0] pid);
      tx_req_t req;
      req.cmd.xmit_view.code = CMD_XMIT;
      req.cmd.xmit_view.rsvd = 2'b00;
      req.cmd.xmit_view.pid  = pid;
      req.wr_data            = '0;
      req.wr                 = 1'b0;
      return req;
   endfunction

   assign dir_rise   = phy_dir & ~dir_q;
   assign vbus_valid = (rx_cmd.vbus_state == VBUS_VALID);
   // valid to invalid only
   assign vbus_lost  = vbus_valid_q & ~vbus_valid & ~opt_ignore_vbus;
   assign line_se0   = (rx_cmd.line_state == ls_se0);

   //////////////////////////////////////////////////
   // main fsm
   //////////////////////////////////////////////////

   always_ff @(posedge clk_suspend) begin
      if (!reset_2) begin
         state        <= rst_wait;
         timer        <= '0;
         dir_q        <= 1'b0;
         vbus_valid_q <= 1'b0;
         tx_start     <= 1'b0;
         pkt_d_sel    <= 1'b0;
         se0_reset    <= 1'b0;
         latch_defer  <= 1'b0;
      end else begin
         dir_q        <= phy_dir;
         vbus_valid_q <= vbus_valid;
         tx_start     <= 1'b0;
         se0_reset    <= 1'b0;
         if (pkt_in_latch && state != pkt_start && state != tx && state != pkt_data) begin
            latch_defer <= 1'b1;
         end
         case (state)
            // debounce, then phy reset write
            rst_wait: begin
               if (timer != TIMER_W'(DEBOUNCE_CYCLES)) begin
                  timer <= timer + 1'b1;
               end else if (!phy_dir) begin
                  tx_start <= 1'b1;
                  state    <= rst_write;
               end
            end
            rst_write: begin
               if (tx_done) begin
                  timer <= '0;
                  state <= rst_wait_dir;
               end
            end
            // phy should take the bus, else start over
            rst_wait_dir: begin
               timer <= timer + 1'b1;
               if (phy_dir) begin
                  state <= rst_rx;
               end else if (timer == TIMER_W'(DIR_TIMEOUT_CYCLES - 1)) begin
                  timer <= '0;
                  state <= rst_wait;
               end
            end
            // first rx_cmd, otg write once dir drops
            rst_rx: begin
               if (!phy_dir) begin
                  tx_start <= 1'b1;
                  state    <= otg_write;
               end
            end
            otg_write: begin
               if (tx_done) begin
                  timer <= '0;
                  state <= idle;
               end
            end
            idle: begin
               if (dir_rise) begin
                  // packet traffic breaks an se0 run
                  if (phy_nxt) begin
                     timer <= '0;
                  end
                  state <= rx;
               end else if (pkt_in_latch || latch_defer) begin
                  latch_defer <= 1'b0;
                  state       <= pkt_start;
               end else if (!line_se0) begin
                  timer <= '0;
               end else if (timer != TIMER_W'(SE0_RESET_CYCLES)) begin
                  timer     <= timer + 1'b1;
                  // single pulse, timer parks at the limit
                  se0_reset <= (timer == TIMER_W'(SE0_RESET_CYCLES - 1));
               end
            end
            rx: begin
               if (!phy_dir) begin
                  state <= idle;
               end
            end
            // first byte is the pid
            pkt_start: begin
               tx_start <= 1'b1;
               state    <= tx;
            end
            tx: begin
               if (tx_done) begin
                  pkt_d_sel <= 1'b1;
                  state     <= pkt_data;
               end
            end
            pkt_data: begin
               if (pkt_in_stp) begin
                  pkt_d_sel <= 1'b0;
                  timer     <= '0;
                  state     <= idle;
               end
            end
            default: state <= rst_wait;
         endcase
         // cable pulled or link disabled
         if (opt_disable_all || vbus_lost) begin
            state     <= rst_wait;
            timer     <= '0;
            tx_start  <= 1'b0;
            pkt_d_sel <= 1'b0;
         end
      end
   end

   // request payload, loaded alongside tx_start
   always_ff @(posedge clk_suspend) begin
      if (state == rst_wait) begin
         tx_req <= reg_write_req(REG_FUNC_CTRL, FUNC_CTRL_RESET_VAL);
      end else if (state == rst_rx) begin
         tx_req <= reg_write_req(REG_OTG_CTRL, 8'h00);
      end else if (state == pkt_start) begin
         tx_req <= xmit_req(pkt_in_byte[3:0]);
      end
   end

   assign rx_expect  = (state == rx) || (state == rst_rx);
   assign pkt_in_cts = (state == idle) & ~phy_dir & ~latch_defer;

endmodule

// ==== hw/ulpi_link_top.sv ====
module ulpi_link_top import ulpi_pkg::*; (
   // clocking and options
   input  logic        clk_suspend,
   input  logic        reset_2,
   input  logic        opt_disable_all,
   input  logic        opt_ignore_vbus,
   // status
   output logic        stat_connected,
   output logic        se0_reset,
   output line_state_t dbg_linestate,
   // ulpi phy
   input  ulpi_byte_t  phy_d_in,
   output ulpi_byte_t  phy_d_out_mux,
   output logic        phy_d_oe,
   input  logic        phy_dir,
   output logic        phy_stp,
   input  logic        phy_nxt,
   // packet layer
   output logic        pkt_out_act,
   output ulpi_byte_t  pkt_out_byte,
   output logic        pkt_out_latch,
   output logic        pkt_in_cts,
   output logic        pkt_in_nxt,
   input  ulpi_byte_t  pkt_in_byte,
   input  logic        pkt_in_latch,
   input  logic        pkt_in_stp
);

   // fsm <-> engine
   tx_req_t tx_req;
   logic    tx_start;
   logic    tx_done;
   logic    pkt_d_sel;

   // decoder <-> fsm
   rx_cmd_t rx_cmd;
   logic    rx_expect;

   //////////////////////////////////////////////////
   // receive side
   //////////////////////////////////////////////////

   ulpi_rx_cmd_decoder rx_dec_i (
      .clk_suspend    (clk_suspend),
      .reset_2        (reset_2),
      .phy_dir        (phy_dir),
      .phy_nxt        (phy_nxt),
      .phy_d_in       (phy_d_in),
      .rx_expect      (rx_expect),
      .rx_cmd         (rx_cmd),
      .stat_connected (stat_connected),
      .dbg_linestate  (dbg_linestate),
      .pkt_out_act    (pkt_out_act),
      .pkt_out_byte   (pkt_out_byte),
      .pkt_out_latch  (pkt_out_latch)
   );

   //////////////////////////////////////////////////
   // transmit side
   //////////////////////////////////////////////////

   ulpi_tx_cmd_engine tx_eng_i (
      .clk_suspend   (clk_suspend),
      .reset_2       (reset_2),
      .tx_start      (tx_start),
      .tx_req        (tx_req),
      .phy_dir       (phy_dir),
      .phy_nxt       (phy_nxt),
      .pkt_d_sel     (pkt_d_sel),
      .pkt_in_byte   (pkt_in_byte),
      .pkt_in_stp    (pkt_in_stp),
      .tx_done       (tx_done),
      .phy_d_out_mux (phy_d_out_mux),
      .phy_d_oe      (phy_d_oe),
      .phy_stp       (phy_stp),
      .pkt_in_nxt    (pkt_in_nxt)
   );

   // main controller
   ulpi_link_fsm fsm_i (
      .clk_suspend     (clk_suspend),
      .reset_2         (reset_2),
      .opt_disable_all (opt_disable_all),
      .opt_ignore_vbus (opt_ignore_vbus),
      .phy_dir         (phy_dir),
      .phy_nxt         (phy_nxt),
      .rx_cmd          (rx_cmd),
      .tx_done         (tx_done),
      .pkt_in_latch    (pkt_in_latch),
      .pkt_in_byte     (pkt_in_byte),
      .pkt_in_stp      (pkt_in_stp),
      .tx_start        (tx_start),
      .tx_req          (tx_req),
      .rx_expect       (rx_expect),
      .pkt_d_sel       (pkt_d_sel),
      .pkt_in_cts      (pkt_in_cts),
      .se0_reset       (se0_reset)
   );

endmodule

// ==== hw/ulpi_pkg.sv ====
package ulpi_pkg;

   //////////////////////////////////////////////////
   // bus types
   //////////////////////////////////////////////////

   typedef logic [7:0] ulpi_byte_t;

   // line state as reported in rx_cmd[1:0]
   typedef enum logic [1:0] {
      ls_se0 = 2'b00,
      ls_j   = 2'b01,
      ls_k   = 2'b10,
      ls_se1 = 2'b11
   } line_state_t;

   // rx_cmd byte, msb first
   typedef struct packed {
      logic        alt_int;
      logic        id_gnd;
      logic [1:0]  rx_event;
      logic [1:0]  vbus_state;
      line_state_t line_state;
   } rx_cmd_t;

   // tx_cmd byte, register form
   typedef struct packed {
      logic [1:0] code;
      logic [5:0] addr;
   } tx_reg_view_t;

   // tx_cmd byte, transmit form
   typedef struct packed {
      logic [1:0] code;
      logic [1:0] rsvd;
      logic [3:0] pid;
   } tx_xmit_view_t;

   // same byte, decoded by command code
   typedef union packed {
      tx_reg_view_t  reg_view;
      tx_xmit_view_t xmit_view;
   } tx_cmd_u;

   // one request to the tx_cmd engine
   typedef struct packed {
      tx_cmd_u    cmd;
      ulpi_byte_t wr_data;
      logic       wr;
   } tx_req_t;

   typedef enum logic [3:0] {
      rst_wait,
      rst_write,
      rst_wait_dir,
      rst_rx,
      otg_write,
      idle,
      rx,
      tx,
      pkt_start,
      pkt_data
   } link_state_e;

   //////////////////////////////////////////////////
   // constants
   //////////////////////////////////////////////////

   localparam logic [1:0] CMD_XMIT  = 2'b01;
   localparam logic [1:0] CMD_REGWR = 2'b10;

   localparam logic [5:0] REG_FUNC_CTRL = 6'h04;
   localparam logic [5:0] REG_OTG_CTRL  = 6'h0A;

   // suspendm off, phy reset, normal opmode, term on, full speed
   localparam ulpi_byte_t FUNC_CTRL_RESET_VAL = 8'h65;

   localparam logic [1:0] VBUS_VALID = 2'b11;

   // short limits, all in clk_suspend cycles
   localparam int DEBOUNCE_CYCLES    = 64;
   localparam int DIR_TIMEOUT_CYCLES = 32;
   localparam int SE0_RESET_CYCLES   = 100;
   localparam int TIMER_W            = 8;

endpackage

// ==== hw/ulpi_rx_cmd_decoder.sv ====
module ulpi_rx_cmd_decoder import ulpi_pkg::*; (
   input  logic        clk_suspend,
   input  logic        reset_2,
   input  logic        phy_dir,
   input  logic        phy_nxt,
   input  ulpi_byte_t  phy_d_in,
   input  logic        rx_expect,
   output rx_cmd_t     rx_cmd,
   output logic        stat_connected,
   output line_state_t dbg_linestate,
   output logic        pkt_out_act,
   output ulpi_byte_t  pkt_out_byte,
   output logic        pkt_out_latch
);

   logic dir_q;
   // dir and nxt rose together, so a packet is coming
   // before its rx_cmd says rx_active
   logic recv_pkt;

   always_ff @(posedge clk_suspend) begin
      if (!reset_2) begin
         dir_q          <= 1'b0;
         recv_pkt       <= 1'b0;
         rx_cmd         <= '0;
         stat_connected <= 1'b0;
         dbg_linestate  <= ls_se0;
      end else begin
         dir_q <= phy_dir;
         // note packet start on the turnaround cycle
         if (phy_dir && !dir_q) begin
            recv_pkt <= phy_nxt;
         end else if (!phy_dir) begin
            recv_pkt <= 1'b0;
         end
         // nxt low with dir high means an rx_cmd byte
         if (rx_expect && phy_dir && !phy_nxt) begin
            rx_cmd <= rx_cmd_t'(phy_d_in);
         end
         // status follows the captured byte by one cycle
         stat_connected <= (rx_cmd.vbus_state == VBUS_VALID);
         dbg_linestate  <= rx_cmd.line_state;
      end
   end

   // receive pass-through, rx_event[0] is rx_active
   assign pkt_out_act   = (rx_cmd.rx_event[0] | recv_pkt) & phy_dir & rx_expect;
   assign pkt_out_latch = pkt_out_act & phy_nxt;
   // zero when no byte is offered
   assign pkt_out_byte  = pkt_out_latch ? phy_d_in : '0;

endmodule

// ==== hw/ulpi_tx_cmd_engine.sv ====
module ulpi_tx_cmd_engine import ulpi_pkg::*; (
   input  logic       clk_suspend,
   input  logic       reset_2,
   input  logic       tx_start,
   input  tx_req_t    tx_req,
   input  logic       phy_dir,
   input  logic       phy_nxt,
   input  logic       pkt_d_sel,
   input  ulpi_byte_t pkt_in_byte,
   input  logic       pkt_in_stp,
   output logic       tx_done,
   output ulpi_byte_t phy_d_out_mux,
   output logic       phy_d_oe,
   output logic       phy_stp,
   output logic       pkt_in_nxt
);

   // turnaround, dir one cycle late
   logic       dir_q;
   // command byte on the bus, waiting for nxt
   logic       cmd_busy;
   // write data byte cycle, then the stp cycle
   logic       data_q;
   logic       stp_q;
   logic       cmd_ack;
   // request payload
   logic       is_wr;
   ulpi_byte_t wr_data;
   ulpi_byte_t d_out;

   // phy takes the command only while the link owns the bus
   assign cmd_ack = cmd_busy & phy_nxt & ~phy_dir;

   //////////////////////////////////////////////////
   // sequencer
   //////////////////////////////////////////////////

   always_ff @(posedge clk_suspend) begin
      if (!reset_2) begin
         dir_q    <= 1'b1;
         cmd_busy <= 1'b0;
         data_q   <= 1'b0;
         stp_q    <= 1'b0;
         d_out    <= '0;
      end else begin
         dir_q  <= phy_dir;
         data_q <= cmd_ack & is_wr;
         stp_q  <= data_q;
         if (tx_start) begin
            cmd_busy <= 1'b1;
            d_out    <= ulpi_byte_t'(tx_req.cmd);
         end else if (cmd_ack) begin
            cmd_busy <= 1'b0;
            // register write: data next, transmit: bus idles at zero
            d_out    <= is_wr ? wr_data : '0;
         end else if (data_q) begin
            // stp cycle carries zero data
            d_out <= '0;
         end
      end
   end

   always_ff @(posedge clk_suspend) begin
      if (tx_start) begin
         is_wr   <= tx_req.wr;
         wr_data <= tx_req.wr_data;
      end
   end

   // transmit is done at nxt, register write at stp
   assign tx_done = (cmd_ack & ~is_wr) | stp_q;

   //////////////////////////////////////////////////
   // bus outputs
   //////////////////////////////////////////////////

   assign phy_d_oe      = ~dir_q;
   // packet layer owns data once the pid is taken
   assign phy_d_out_mux = pkt_d_sel ? pkt_in_byte : d_out;
   assign phy_stp       = stp_q | (pkt_d_sel & pkt_in_stp);
   assign pkt_in_nxt    = pkt_d_sel & phy_nxt;

endmodule
